// ==== logic/ctrl_flash.sv ====
/*
  read-only controller for an 8 bit parallel NOR flash
  builds 32 bit words from four timed byte reads, places bytes
  by endianness, rejects writes with err, keeps chip in read mode
*/

`timescale 1ns/1ps

`include "flash_defines.svh"

module ctrl_flash import flash_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  qmem_req_t            req,
  output qmem_rsp_t            rsp,
  output flash_pins_t          pins,
  input  logic [`FLASH_DW-1:0] flash_dq
);

  rd_state_t             state;
  dly_cnt_t              timer;      // cycles left for current byte
  logic [`FLASH_AW-1:0]  fl_adr;     // address on the pins
  logic [`QMEM_DW-1:0]   dat_r;      // assembled word
  logic                  ack_q;
  logic                  err_q;
  logic                  rd_mode;    // chip out of reset, selected
  logic                  rd_busy;    // in one of the byte states
  logic                  byte_done;  // current byte may be sampled

  // lane for a byte offset, byte 0 is msb lane in big endian
  function automatic logic [1:0] byte_lane(input logic [1:0] idx);
    if (`FLASH_BIG_ENDIAN) begin
      return 2'd3 - idx;
    end
    return idx;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // chip control, read mode once reset is gone
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_mode <= 1'b0;   // ce_n high, rst_n low while in reset
    end else begin
      rd_mode <= 1'b1;
    end
  end

  always_comb begin
    pins.adr   = fl_adr;
    pins.ce_n  = ~rd_mode;
    pins.rst_n = rd_mode;
    pins.oe_n  = 1'b0;     // outputs always enabled, read only
    pins.we_n  = 1'b1;     // never program
  end

  ////////////////////////////////////////////////////////////////////////////
  // read engine
  ////////////////////////////////////////////////////////////////////////////

  assign rd_busy   = state inside {RD_B0, RD_B1, RD_B2, RD_B3};
  assign byte_done = rd_busy && (timer == '0);

  // sel and dat_w are ignored, every read fetches the whole word
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state  <= RD_IDLE;
      timer  <= '0;
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
      fl_adr <= '0;
    end else begin
      ack_q <= 1'b0;                      // pulses only
      err_q <= 1'b0;
      if (timer != '0) begin
        timer <= timer - 1'b1;
      end
      case (state)
        RD_IDLE: begin
          if (req.cs && req.we) begin
            state <= RD_ERR;              // no flash access at all
            ack_q <= 1'b1;
            err_q <= 1'b1;
          end else if (req.cs) begin
            fl_adr <= {req.adr[`FLASH_AW-1:2], 2'b00};  // word aligned
            timer  <= dly_cnt_t'(`FLASH_DLY);
            state  <= RD_B0;
          end
        end
        RD_B0, RD_B1, RD_B2: begin
          if (timer == '0) begin
            fl_adr[1:0] <= fl_adr[1:0] + 2'd1;   // next byte
            timer       <= dly_cnt_t'(`FLASH_DLY);
            state       <= rd_state_t'(state + 3'd1);
          end
        end
        RD_B3: begin
          // ack leads the last byte sample by one cycle
          if (timer == dly_cnt_t'(1)) begin
            ack_q <= 1'b1;
          end
          if (timer == '0) begin
            state <= RD_IDLE;
          end
        end
        RD_ERR: begin
          state <= RD_IDLE;               // ack/err high this cycle
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  // byte capture into its lane
  always_ff @(posedge clk) begin
    if (byte_done) begin
      dat_r[{byte_lane(fl_adr[1:0]), 3'b000} +: `FLASH_DW] <= flash_dq;
    end
  end

  always_comb begin
    rsp.dat_r = dat_r;
    rsp.ack   = ack_q;
    rsp.err   = err_q;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_ack_pulse: assert property (
    @(posedge clk) disable iff (rst)
    rsp.ack |=> !rsp.ack
  ) else $error("ctrl_flash: ack longer than one cycle");

  // byte state and pin address must agree for the whole byte window
  a_byte_adr: assert property (
    @(posedge clk) disable iff (rst)
    rd_busy |-> (pins.adr[1:0] == state[1:0])
  ) else $error("ctrl_flash: flash address out of step with byte state");

endmodule

// ==== logic/flash_defines.svh ====
/*
  configuration macros for the boot flash subsystem
  flash and qmem bus widths, per-byte access delay, byte order
*/

`ifndef FLASH_DEFINES_SVH
`define FLASH_DEFINES_SVH

// flash side
`define FLASH_AW 22          // flash byte address width
`define FLASH_DW 8           // flash data bus width

// qmem side
`define QMEM_AW 22           // qmem byte address width
`define QMEM_DW 32           // qmem data width
`define QMEM_SW 4            // byte selects, one per lane

// wait cycles per byte, 3 covers a 70ns part at 50MHz with margin
`define FLASH_DLY 3

// 1 = big endian, byte 0 lands in dat_r[31:24]
// 0 = little endian, byte 0 lands in dat_r[7:0]
`define FLASH_BIG_ENDIAN 1

`endif

// ==== logic/flash_pkg.sv ====
/*
  shared types for the boot flash subsystem
  qmem request and response structs, flash pin bundle,
  controller and arbiter state enums, access timer type
*/

`include "flash_defines.svh"

package flash_pkg;

  // one qmem master request, held stable until ack
  typedef struct packed {
    logic                cs;
    logic                we;
    logic [`QMEM_AW-1:0] adr;     // byte address
    logic [`QMEM_SW-1:0] sel;     // carried, not used by the flash
    logic [`QMEM_DW-1:0] dat_w;
  } qmem_req_t;

  // response, dat_r valid the cycle after ack
  typedef struct packed {
    logic [`QMEM_DW-1:0] dat_r;
    logic                ack;     // single cycle pulse
    logic                err;     // qualified by ack
  } qmem_rsp_t;

  // outputs to the NOR chip, all control lines active low
  typedef struct packed {
    logic [`FLASH_AW-1:0] adr;
    logic                 ce_n;
    logic                 we_n;
    logic                 oe_n;
    logic                 rst_n;
  } flash_pins_t;

  // low two bits of the byte states equal the byte offset
  typedef enum logic [2:0] {
    RD_IDLE = 3'd0,
    RD_B0   = 3'd4,
    RD_B1   = 3'd5,
    RD_B2   = 3'd6,
    RD_B3   = 3'd7,
    RD_ERR  = 3'd1
  } rd_state_t;

  typedef enum logic [1:0] {
    OWN_NONE  = 2'd0,
    OWN_DATA  = 2'd1,
    OWN_INSTR = 2'd2
  } arb_owner_t;

  // access timer, just wide enough to hold FLASH_DLY
  typedef logic [$clog2(`FLASH_DLY + 1)-1:0] dly_cnt_t;

endpackage

// ==== logic/flash_subsys_top.sv ====
/*
  boot flash subsystem top level
  data and fetch qmem ports, arbiter, flash read controller
*/

`timescale 1ns/1ps

`include "flash_defines.svh"

module flash_subsys_top import flash_pkg::*; (
  // system
  input  logic                 clk,
  input  logic                 rst,
  // data port, higher priority
  input  qmem_req_t            dreq,
  output qmem_rsp_t            drsp,
  // instruction fetch port
  input  qmem_req_t            ireq,
  output qmem_rsp_t            irsp,
  // NOR flash chip
  output flash_pins_t          flash_pins,
  input  logic [`FLASH_DW-1:0] flash_dq
);

  ////////////////////////////////////////////////////////////////////////////
  // arbiter to controller link
  ////////////////////////////////////////////////////////////////////////////

  qmem_req_t creq;     // granted request
  qmem_rsp_t crsp;     // controller response, routed back by owner

  ////////////////////////////////////////////////////////////////////////////
  // arbiter
  ////////////////////////////////////////////////////////////////////////////

  // one request at a time, data port wins ties
  qmem_arbiter i_arbiter (
    .clk  (clk),
    .rst  (rst),
    .dreq (dreq),
    .ireq (ireq),
    .drsp (drsp),
    .irsp (irsp),
    .creq (creq),
    .crsp (crsp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // flash controller
  ////////////////////////////////////////////////////////////////////////////

  // four byte reads per word, writes answered with err
  ctrl_flash i_ctrl_flash (
    .clk      (clk),
    .rst      (rst),
    .req      (creq),
    .rsp      (crsp),
    .pins     (flash_pins),
    .flash_dq (flash_dq)
  );

endmodule

// ==== logic/qmem_arbiter.sv ====
/*
  two port qmem arbiter in front of the flash controller
  fixed priority, data port over instruction fetch
  grant lock until the cycle after ack, response routing
*/

`timescale 1ns/1ps

`include "flash_defines.svh"

module qmem_arbiter import flash_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  qmem_req_t dreq,   // data port
  input  qmem_req_t ireq,   // instruction fetch port
  output qmem_rsp_t drsp,
  output qmem_rsp_t irsp,
  output qmem_req_t creq,   // towards controller
  input  qmem_rsp_t crsp
);

  arb_owner_t owner;        // locked grant
  arb_owner_t grant;        // effective grant this cycle

  ////////////////////////////////////////////////////////////////////////////
  // grant selection
  ////////////////////////////////////////////////////////////////////////////

  // an existing owner always wins, otherwise pick by priority
  always_comb begin
    if (owner != OWN_NONE) begin
      grant = owner;
    end else if (dreq.cs) begin
      grant = OWN_DATA;                 // data port first
    end else if (ireq.cs) begin
      grant = OWN_INSTR;
    end else begin
      grant = OWN_NONE;
    end
  end

  // lock on acceptance, drop at the edge that ends the ack cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      owner <= OWN_NONE;
    end else if (crsp.ack) begin
      owner <= OWN_NONE;                // data cycle runs unowned
    end else if (owner == OWN_NONE) begin
      owner <= grant;                   // stays none if nobody asks
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // request forwarding and response routing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (grant)
      OWN_DATA:  creq = dreq;
      OWN_INSTR: creq = ireq;
      default:   creq = '0;             // cs low, controller idles
    endcase
  end

  // the losing port sees no ack and simply keeps waiting
  always_comb begin
    drsp.dat_r = crsp.dat_r;            // qualified by ack at the master
    irsp.dat_r = crsp.dat_r;
    drsp.ack   = crsp.ack && (owner == OWN_DATA);
    drsp.err   = crsp.err && (owner == OWN_DATA);
    irsp.ack   = crsp.ack && (owner == OWN_INSTR);
    irsp.err   = crsp.err && (owner == OWN_INSTR);
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // controller acks only what was granted, so never both
  a_single_ack: assert property (
    @(posedge clk) disable iff (rst)
    !(drsp.ack && irsp.ack)
  ) else $error("qmem_arbiter: ack on both ports");

  // request seen by the controller holds steady until its ack
  a_owner_locked: assert property (
    @(posedge clk) disable iff (rst)
    (owner != OWN_NONE) && !crsp.ack |-> $stable(creq)
  ) else $error("qmem_arbiter: granted request changed during transfer");

  // every ack must land on a port, i.e. the controller only
  // finishes transfers that were granted
  a_ack_owned: assert property (
    @(posedge clk) disable iff (rst)
    crsp.ack |-> (owner != OWN_NONE)
  ) else $error("qmem_arbiter: ack without owner");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the boot flash testbench with Verilator
set -e

cd "$(dirname "$0")"

# unique x values so that reads outside the access window come back as junk
verilator --binary --timing --assert -Wno-fatal \
  --x-assign unique --x-initial unique \
  --top-module tb_flash_subsys -f verilog.f

status=0
./obj_dir/Vtb_flash_subsys > sim.log 2>&1 || status=$?
cat sim.log

# an assertion stop ends the run early with a nonzero status
if [ "$status" -ne 0 ] || grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"

// ==== test/flash_chip_model.sv ====
/*
  behavioral 8 bit parallel NOR flash for the testbench
  4 KB array repeated over the address range, access time model,
  check that write enable stays high in read mode
*/

`timescale 1ns/1ps

`include "flash_defines.svh"

module flash_chip_model import flash_pkg::*; (
  input  logic                 clk,
  input  flash_pins_t          pins,
  output logic [`FLASH_DW-1:0] dq
);

  logic [7:0]           mem [0:4095];   // loaded by the testbench
  logic [`FLASH_AW-1:0] adr_q;          // address seen at the last edge
  int                   stable;         // full cycles the address has been held
  int                   err_cnt;

  initial begin
    adr_q   = '0;
    stable  = 0;
    err_cnt = 0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // access time
  ////////////////////////////////////////////////////////////////////////////

  // a new address seen at an edge has been held for one full cycle
  always @(posedge clk) begin
    adr_q <= pins.adr;
    if (pins.adr != adr_q) begin
      stable <= 1;
    end else if (stable < `FLASH_DLY) begin
      stable <= stable + 1;               // saturates at the delay
    end
  end

  // data only after the access time, x while the address is fresh
  always_comb begin
    if (!pins.ce_n && !pins.oe_n && (pins.adr == adr_q) && (stable >= `FLASH_DLY)) begin
      dq = mem[pins.adr[11:0]];           // 4 KB image mirrored
    end else begin
      dq = 'x;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus checks
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (pins.rst_n && !pins.we_n) begin
      err_cnt = err_cnt + 1;
      $display("flash chip: write enable pulled low in read mode at %0t", $time);
    end
  end

endmodule

// ==== test/tb_flash_subsys.sv ====
/*
  testbench for the boot flash subsystem
  clock and reset, LCG driven traffic on both qmem ports,
  reference copy of the flash array, response checks, final report
*/

`timescale 1ns/1ps

`include "flash_defines.svh"

module tb_flash_subsys import flash_pkg::*; ();

  localparam int NOPS     = 52;    // ops per port over all phases
  localparam int MEM_SIZE = 4096;  // flash image repeats every 4 KB
  localparam int TIMEOUT  = 400;   // cycles per wait, one word takes about 18

  logic                 clk;
  logic                 rst;
  qmem_req_t            dreq;
  qmem_req_t            ireq;
  qmem_rsp_t            drsp;
  qmem_rsp_t            irsp;
  flash_pins_t          flash_pins;
  logic [`FLASH_DW-1:0] flash_dq;

  logic [7:0]           ref_mem [MEM_SIZE];   // expected flash contents
  logic                 op_we   [2][NOPS];    // op lists, index 0 is the data port
  logic [`QMEM_AW-1:0]  op_adr  [2][NOPS];
  int                   op_gap  [2][NOPS];    // idle cycles before op, 0 keeps cs up
  logic [31:0]          seed;
  int                   err_cnt;
  int                   to_cnt;
  int                   cyc;

  flash_subsys_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .dreq       (dreq),
    .drsp       (drsp),
    .ireq       (ireq),
    .irsp       (irsp),
    .flash_pins (flash_pins),
    .flash_dq   (flash_dq)
  );

  flash_chip_model i_chip (
    .clk  (clk),
    .pins (flash_pins),
    .dq   (flash_dq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                // 100 MHz
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;                       // time stamp for ack order
  end

  // the arbiter may never complete both ports at once
  always @(negedge clk) begin
    if (!rst && drsp.ack && irsp.ack) begin
      err_cnt++;
      $display("both ports got ack in the same cycle at %0t", $time);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // word as the flash holds it, byte order per FLASH_BIG_ENDIAN
  function automatic logic [31:0] expect_word(input logic [`QMEM_AW-1:0] adr);
    logic [11:0] base;
    logic [31:0] w;
    base = {adr[11:2], 2'b00};            // whole aligned word, sel ignored
    w = {ref_mem[base], ref_mem[base + 12'd1],
         ref_mem[base + 12'd2], ref_mem[base + 12'd3]};
    if (`FLASH_BIG_ENDIAN == 0) begin
      w = {w[7:0], w[15:8], w[23:16], w[31:24]};   // byte 0 in low lane
    end
    return w;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic gen_ops(input int first, input int count, input int gap_lo,
                         input int gap_hi, input int wr_thr);
    logic [31:0] r;
    int          p;
    int          k;
    for (p = 0; p < 2; p++) begin
      for (k = first; k < first + count; k++) begin
        r = next_rand();
        op_adr[p][k] = r[31:10];          // any byte address, unaligned too
        r = next_rand();
        op_we[p][k]  = (int'(r[31:24]) < wr_thr);
        op_gap[p][k] = gap_lo + int'(r[23:20]) % (gap_hi - gap_lo + 1);
      end
    end
  endtask

  task automatic drive_req(input bit port, input qmem_req_t req);
    if (port) begin
      ireq = req;
    end else begin
      dreq = req;
    end
  endtask

  task automatic report_stray_ack(input string nm);
    err_cnt++;
    $display("%s got an ack with no request pending at %0t", nm, $time);
  endtask

  // one cycle on a port, checks the word of the last read if due
  task automatic tick(input bit port, inout bit pend, input logic [31:0] exp_w,
                      output qmem_rsp_t rsp);
    @(negedge clk);
    rsp = port ? irsp : drsp;
    if (pend) begin
      check_val(port ? "irsp.dat_r" : "drsp.dat_r", rsp.dat_r, exp_w);
      pend = 1'b0;
    end
  endtask

  // runs ops first..first+count-1 of a port, solo allows the pin check on writes
  task automatic run_port(input bit port, input int first, input int count,
                          input bit solo, output int ack_cyc);
    qmem_req_t            req;
    qmem_rsp_t            rsp;
    logic [31:0]          exp_w;
    logic [`FLASH_AW-1:0] adr_snap;
    bit                   pend;
    int                   k;
    int                   n;
    string                nm;
    nm      = port ? "irsp" : "drsp";
    pend    = 1'b0;
    exp_w   = '0;
    ack_cyc = -1;
    for (k = first; k < first + count; k++) begin
      if (op_gap[port][k] != 0) begin
        drive_req(port, '0);              // cs low during the gap
        for (n = 0; n < op_gap[port][k]; n++) begin
          tick(port, pend, exp_w, rsp);
          if (rsp.ack) report_stray_ack(nm);
        end
      end
      req.cs    = 1'b1;
      req.we    = op_we[port][k];
      req.adr   = op_adr[port][k];
      req.sel   = '1;
      req.dat_w = {op_adr[port][k][9:0], op_adr[port][k]};
      drive_req(port, req);
      adr_snap = flash_pins.adr;
      n   = 0;
      rsp = '0;
      while (!rsp.ack && n < TIMEOUT) begin
        tick(port, pend, exp_w, rsp);     // held until ack
        n++;
      end
      if (!rsp.ack) begin
        to_cnt++;
        $display("timeout, %s saw no ack for address %h", nm, req.adr);
        drive_req(port, '0);
        return;
      end
      ack_cyc = cyc;
      check_val({nm, ".err"}, {31'b0, rsp.err}, {31'b0, req.we});
      if (req.we && solo) begin
        check_val("flash_pins.adr", 32'(flash_pins.adr), 32'(adr_snap));
      end
      if (!req.we) begin
        pend  = 1'b1;                     // word lands one cycle after ack
        exp_w = expect_word(req.adr);
      end
    end
    drive_req(port, '0);
    if (pend) begin
      tick(port, pend, exp_w, rsp);
      if (rsp.ack) report_stray_ack(nm);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    int          k;
    int          ack_d;
    int          ack_i;
    seed    = 32'ha4a3c34e;
    err_cnt = 0;
    to_cnt  = 0;
    cyc     = 0;
    rst     = 1'b1;
    dreq    = '0;
    ireq    = '0;

    // flash image, one LCG byte per location
    for (k = 0; k < MEM_SIZE; k++) begin
      r             = next_rand();
      ref_mem[k]    = r[31:24];
      i_chip.mem[k] = r[31:24];
    end

    gen_ops(0, 8, 1, 3, 0);               // plain reads
    gen_ops(8, 6, 0, 2, 0);               // writes between reads
    for (k = 8; k < 14; k++) begin
      op_we[0][k] = (k % 2 == 0);
      op_we[1][k] = (k % 2 == 1);
    end
    gen_ops(14, 6, 0, 0, 48);             // both ports in the same cycle
    gen_ops(20, 24, 0, 3, 32);            // free running mix
    gen_ops(44, 8, 0, 0, 32);             // cs kept high after ack

    for (k = 0; k < 5; k++) begin
      @(posedge clk);
    end
    @(negedge clk);
    check_val("drsp.ack", {31'b0, drsp.ack}, 32'd0);
    check_val("irsp.ack", {31'b0, irsp.ack}, 32'd0);
    check_val("drsp.err", {31'b0, drsp.err}, 32'd0);
    check_val("irsp.err", {31'b0, irsp.err}, 32'd0);
    check_val("flash_pins.ce_n", {31'b0, flash_pins.ce_n}, 32'd1);
    check_val("flash_pins.rst_n", {31'b0, flash_pins.rst_n}, 32'd0);
    rst = 1'b0;
    @(negedge clk);                       // chip enters read mode
    check_val("flash_pins.ce_n", {31'b0, flash_pins.ce_n}, 32'd0);
    check_val("flash_pins.rst_n", {31'b0, flash_pins.rst_n}, 32'd1);
    check_val("flash_pins.oe_n", {31'b0, flash_pins.oe_n}, 32'd0);
    check_val("flash_pins.we_n", {31'b0, flash_pins.we_n}, 32'd1);

    run_port(1'b0, 0, 8, 1'b1, ack_d);
    run_port(1'b1, 0, 8, 1'b1, ack_i);
    run_port(1'b0, 8, 6, 1'b1, ack_d);
    run_port(1'b1, 8, 6, 1'b1, ack_i);

    // both raise cs together, data port goes first
    for (k = 14; k < 20; k++) begin
      fork
        run_port(1'b0, k, 1, 1'b0, ack_d);
        run_port(1'b1, k, 1, 1'b0, ack_i);
      join
      if (ack_d >= 0 && ack_i >= 0 && ack_d >= ack_i) begin
        err_cnt++;
        $display("fetch port was served before the data port at %0t", $time);
      end
    end

    fork
      run_port(1'b0, 20, 24, 1'b0, ack_d);
      run_port(1'b1, 20, 24, 1'b0, ack_i);
    join

    run_port(1'b0, 44, 8, 1'b1, ack_d);
    run_port(1'b1, 44, 8, 1'b1, ack_i);

    $display("errors: %0d mismatch, %0d timeout, %0d flash chip",
             err_cnt, to_cnt, i_chip.err_cnt);
    if (err_cnt == 0 && to_cnt == 0 && i_chip.err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/flash_pkg.sv
logic/qmem_arbiter.sv
logic/ctrl_flash.sv
logic/flash_subsys_top.sv
test/flash_chip_model.sv
test/tb_flash_subsys.sv
